// File: source/rmii_pkg.sv
/* Constants of the RMII port for lane and word widths, frame format,
   CRC-32 parameters and buffer sizes */
package rmii_pkg;

    ////////////////////////////////////////
    // RMII lane and user words
    ////////////////////////////////////////
    localparam int DIBIT_W         = 2;
    localparam int BYTE_W          = 8;
    // Bit 8 flags the last byte of a frame
    localparam int WORD_W          = 9;
    localparam int DIBITS_PER_BYTE = 4;

    ////////////////////////////////////////
    // Frame format
    ////////////////////////////////////////
    localparam logic [DIBIT_W-1:0] PREAMBLE_DIBIT = 2'b01;
    localparam logic [DIBIT_W-1:0] SFD_DIBIT      = 2'b11;

    localparam int FCS_BYTES       = 4;
    // Counted with the FCS included
    localparam int MIN_FRAME_BYTES = 64;

    ////////////////////////////////////////
    // Reflected CRC-32
    ////////////////////////////////////////
    localparam int CRC_W = 32;

    localparam logic [CRC_W-1:0] CRC_POLY    = 32'hEDB8_8320;
    localparam logic [CRC_W-1:0] CRC_INIT    = 32'hFFFF_FFFF;
    // Register left behind by a good frame with its FCS
    localparam logic [CRC_W-1:0] CRC_RESIDUE = 32'hDEBB_20E3;

    ////////////////////////////////////////
    // Buffers
    ////////////////////////////////////////
    localparam int BUFFER_DEPTH   = 2048;
    localparam int BUFFER_ADDR_W  = 11;

    localparam int TX_QUEUE_DEPTH = 16;
    localparam int TX_ADDR_W      = 4;

endpackage

// File: source/rx_byte_if.sv
/* Byte stream from the RMII frame decoder to the FCS checker */
`timescale 1ns/10ps

interface rx_byte_if import rmii_pkg::*;
();

    logic   [BYTE_W-1:0]    data;
    logic                   valid;
    logic                   first;
    logic                   last;
    // Only ever together with last
    logic                   error;

    modport source (
        output  data,
        output  valid,
        output  first,
        output  last,
        output  error
    );

    modport sink (
        input   data,
        input   valid,
        input   first,
        input   last,
        input   error
    );

endinterface

// File: source/payload_if.sv
/* Checked payload bytes from the FCS checker to the frame buffer */
`timescale 1ns/10ps

interface payload_if import rmii_pkg::*;
();

    logic   [BYTE_W-1:0]    data;
    logic                   valid;
    logic                   last;
    logic                   good;
    // May also arrive alone, without a byte
    logic                   abort;

    modport source (
        output  data,
        output  valid,
        output  last,
        output  good,
        output  abort
    );

    modport sink (
        input   data,
        input   valid,
        input   last,
        input   good,
        input   abort
    );

endinterface

// File: source/rmii_frame_decoder.sv
/* RMII receive decoder with preamble and delimiter hunt, dibit to byte
   assembly and frame end marking */
`timescale 1ns/10ps

module rmii_frame_decoder import rmii_pkg::*;
(
    input   wire                    clock,
    input   wire                    arst_n,
    input   wire    [DIBIT_W-1:0]   rmii_receive_data,
    input   wire                    rmii_receive_data_enable,
    input   wire                    rmii_receive_data_error,

    rx_byte_if.source               rx_bytes
);

logic                   in_frame;
logic                   preamble_seen;
logic   [1:0]           dibit_count;
logic                   error_seen;
logic                   held_valid;
logic                   held_first;
logic                   first_pending;
logic   [BYTE_W-1:0]    shift_reg;
logic   [BYTE_W-1:0]    held_byte;
logic   [BYTE_W-1:0]    assembled;
logic                   byte_done;
logic                   frame_end;

assign  assembled   =   {rmii_receive_data, shift_reg[BYTE_W-1:DIBIT_W]};
assign  byte_done   =   in_frame && rmii_receive_data_enable &&
                        (dibit_count == DIBITS_PER_BYTE - 1);
// Carrier dropped while inside a frame
assign  frame_end   =   in_frame && !rmii_receive_data_enable;

////////////////////////////////////////
// Frame tracking and output strobes
////////////////////////////////////////
always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        in_frame        <= 1'b0;
        preamble_seen   <= 1'b0;
        dibit_count     <= '0;
        error_seen      <= 1'b0;
        held_valid      <= 1'b0;
        held_first      <= 1'b0;
        first_pending   <= 1'b0;
        rx_bytes.valid  <= 1'b0;
        rx_bytes.first  <= 1'b0;
        rx_bytes.last   <= 1'b0;
        rx_bytes.error  <= 1'b0;
    end else begin
        // The held byte leaves when the next one completes or at frame end
        rx_bytes.valid  <= (byte_done && held_valid) || frame_end;
        rx_bytes.first  <= ((byte_done && held_valid) || frame_end) && held_first;
        rx_bytes.last   <= frame_end;
        rx_bytes.error  <= frame_end &&
                           (error_seen || (dibit_count != 2'd0) || !held_valid);

        if (!in_frame) begin
            if (rmii_receive_data_enable) begin
                if (rmii_receive_data == SFD_DIBIT && preamble_seen) begin
                    in_frame        <= 1'b1;
                    dibit_count     <= '0;
                    error_seen      <= 1'b0;
                    held_valid      <= 1'b0;
                    held_first      <= 1'b0;
                    first_pending   <= 1'b1;
                end
                preamble_seen <= (rmii_receive_data == PREAMBLE_DIBIT);
            end else begin
                preamble_seen <= 1'b0;
            end
        end else if (rmii_receive_data_enable) begin
            dibit_count <= dibit_count + 2'd1;
            if (rmii_receive_data_error) begin
                error_seen <= 1'b1;
            end
            if (byte_done) begin
                held_valid      <= 1'b1;
                held_first      <= first_pending;
                first_pending   <= 1'b0;
            end
        end else begin
            in_frame        <= 1'b0;
            preamble_seen   <= 1'b0;
            held_valid      <= 1'b0;
        end
    end
end

// Dibits land least significant first
always_ff @(posedge clock) begin
    if (in_frame && rmii_receive_data_enable) begin
        shift_reg <= assembled;
    end
    if (byte_done) begin
        held_byte <= assembled;
    end
    rx_bytes.data <= held_byte;
end

endmodule

// File: source/fcs_checker.sv
/* CRC-32 and length check of received frames, four byte delay line
   that strips the FCS */
`timescale 1ns/10ps

module fcs_checker import rmii_pkg::*;
(
    input   wire            clock,
    input   wire            arst_n,

    rx_byte_if.sink         rx_bytes,
    payload_if.source       payload
);

logic   [CRC_W-1:0]         crc;
logic   [CRC_W-1:0]         crc_next;
logic   [BUFFER_ADDR_W-1:0] byte_count;
logic   [BUFFER_ADDR_W-1:0] count_next;
logic   [BYTE_W-1:0]        delay_data  [FCS_BYTES];
logic   [FCS_BYTES-1:0]     delay_valid;
logic                       release_valid;
logic                       frame_ok;
logic                       frame_done;

function automatic logic [CRC_W-1:0] crc_byte(
    input logic [CRC_W-1:0]     crc_in,
    input logic [BYTE_W-1:0]    data_in
);
    logic [CRC_W-1:0] c;
    c = crc_in;
    for (int i = 0; i < BYTE_W; i++) begin
        if (c[0] ^ data_in[i]) begin
            c = (c >> 1) ^ CRC_POLY;
        end else begin
            c = c >> 1;
        end
    end
    return c;
endfunction

// A first byte restarts the CRC, the count and the delay line
assign  crc_next        =   crc_byte(rx_bytes.first ? CRC_INIT : crc, rx_bytes.data);
assign  count_next      =   rx_bytes.first ? BUFFER_ADDR_W'(1) :
                            (&byte_count) ? byte_count : byte_count + 1'b1;
assign  release_valid   =   !rx_bytes.first && delay_valid[FCS_BYTES-1];

assign  frame_ok        =   (crc_next == CRC_RESIDUE) &&
                            (count_next >= MIN_FRAME_BYTES) && !rx_bytes.error;
assign  frame_done      =   rx_bytes.valid && rx_bytes.last;

////////////////////////////////////////
// Release path in the same cycle as the input
////////////////////////////////////////
assign  payload.data    =   delay_data[FCS_BYTES-1];
assign  payload.valid   =   rx_bytes.valid && release_valid;
assign  payload.last    =   frame_done && release_valid;
assign  payload.good    =   frame_done && release_valid && frame_ok;
assign  payload.abort   =   frame_done && (!release_valid || !frame_ok);

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        crc         <= CRC_INIT;
        byte_count  <= '0;
        delay_valid <= '0;
    end else if (rx_bytes.valid) begin
        crc         <= crc_next;
        byte_count  <= count_next;
        if (rx_bytes.last) begin
            delay_valid <= '0;
        end else if (rx_bytes.first) begin
            delay_valid <= FCS_BYTES'(1);
        end else begin
            delay_valid <= {delay_valid[FCS_BYTES-2:0], 1'b1};
        end
    end
end

always_ff @(posedge clock) begin
    if (rx_bytes.valid) begin
        delay_data[0] <= rx_bytes.data;
        for (int i = 1; i < FCS_BYTES; i++) begin
            delay_data[i] <= delay_data[i-1];
        end
    end
end

endmodule

// File: source/frame_buffer.sv
/* Receive frame buffer with speculative writes, commit and rollback,
   and the registered user read port */
`timescale 1ns/10ps

module frame_buffer import rmii_pkg::*;
(
    input   wire                    clock,
    input   wire                    arst_n,

    payload_if.sink                 payload,

    input   wire                    receive_data_enable,
    output  logic   [WORD_W-1:0]    receive_data,
    output  logic                   receive_data_valid
);

logic   [WORD_W-1:0]        memory  [BUFFER_DEPTH];
logic   [BUFFER_ADDR_W-1:0] write_pointer;
logic   [BUFFER_ADDR_W-1:0] write_next;
logic   [BUFFER_ADDR_W-1:0] commit_pointer;
logic   [BUFFER_ADDR_W-1:0] read_pointer;
logic                       overflow;
logic                       commit_pending;
logic                       full;
logic                       write_ok;
logic                       frame_bad;
logic                       commit;
logic                       rollback;
logic                       pop;

assign  write_next  =   write_pointer + 1'b1;
// One slot stays free so that full and empty differ
assign  full        =   (write_next == read_pointer);
assign  write_ok    =   payload.valid && !full && !overflow;
assign  frame_bad   =   overflow || (payload.valid && full);

assign  commit      =   payload.good && !frame_bad;
assign  rollback    =   payload.abort || (payload.good && frame_bad);

// Only committed words can be popped
assign  pop         =   receive_data_enable && (read_pointer != commit_pointer);

////////////////////////////////////////
// Pointers
////////////////////////////////////////
always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        write_pointer       <= '0;
        commit_pointer      <= '0;
        read_pointer        <= '0;
        overflow            <= 1'b0;
        commit_pending      <= 1'b0;
        receive_data_valid  <= 1'b0;
    end else begin
        if (rollback) begin
            write_pointer <= commit_pointer;
        end else if (write_ok) begin
            write_pointer <= write_next;
        end

        if (commit || rollback) begin
            overflow <= 1'b0;
        end else if (payload.valid && full) begin
            overflow <= 1'b1;
        end

        // Commit pointer catches up once the last write has landed
        commit_pending <= commit;
        if (commit_pending) begin
            commit_pointer <= write_pointer;
        end

        if (pop) begin
            read_pointer <= read_pointer + 1'b1;
        end
        receive_data_valid <= pop;
    end
end

always_ff @(posedge clock) begin
    if (write_ok) begin
        memory[write_pointer] <= {payload.last, payload.data};
    end
    if (pop) begin
        receive_data <= memory[read_pointer];
    end
end

endmodule

// File: source/rmii_transmit_shipper.sv
/* Transmit queue and byte to dibit shifter of the RMII port */
`timescale 1ns/10ps

module rmii_transmit_shipper import rmii_pkg::*;
(
    input   wire                    clock,
    input   wire                    arst_n,
    input   wire    [WORD_W-1:0]    transmit_data,
    input   wire                    transmit_data_enable,

    output  logic   [DIBIT_W-1:0]   rmii_transmit_data,
    output  logic                   rmii_transmit_data_valid
);

logic   [WORD_W-1:0]    queue   [TX_QUEUE_DEPTH];
logic   [TX_ADDR_W:0]   queue_write;
logic   [TX_ADDR_W:0]   queue_read;
logic   [WORD_W-1:0]    queue_head;
logic                   queue_empty;
logic                   queue_full;
logic                   push;

logic   [BYTE_W-1:0]    shift_reg;
logic   [1:0]           dibit_count;
logic                   active;
logic                   word_last;
logic                   byte_end;
logic                   load;

////////////////////////////////////////
// Queue
////////////////////////////////////////
assign  queue_head  =   queue[queue_read[TX_ADDR_W-1:0]];
assign  queue_empty =   (queue_write == queue_read);
assign  queue_full  =   (queue_write == {~queue_read[TX_ADDR_W], queue_read[TX_ADDR_W-1:0]});
assign  push        =   transmit_data_enable && !queue_full;

assign  byte_end    =   active && (dibit_count == DIBITS_PER_BYTE - 1);
// Back to back bytes except after a frame's last byte
assign  load        =   !queue_empty && (!active || (byte_end && !word_last));

always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
        queue_write                 <= '0;
        queue_read                  <= '0;
        dibit_count                 <= '0;
        active                      <= 1'b0;
        rmii_transmit_data_valid    <= 1'b0;
    end else begin
        if (push) begin
            queue_write <= queue_write + 1'b1;
        end
        if (load) begin
            queue_read <= queue_read + 1'b1;
        end

        rmii_transmit_data_valid <= active;
        if (load) begin
            active      <= 1'b1;
            dibit_count <= '0;
        end else if (active) begin
            dibit_count <= dibit_count + 2'd1;
            if (byte_end) begin
                active <= 1'b0;
            end
        end
    end
end

always_ff @(posedge clock) begin
    if (push) begin
        queue[queue_write[TX_ADDR_W-1:0]] <= transmit_data;
    end
    if (active) begin
        rmii_transmit_data <= shift_reg[DIBIT_W-1:0];
    end
    if (load) begin
        shift_reg <= queue_head[BYTE_W-1:0];
        word_last <= queue_head[WORD_W-1];
    end else if (active) begin
        shift_reg <= shift_reg >> DIBIT_W;
    end
end

endmodule

// File: source/rmii_port.sv
/* RMII port top level wiring the receive chain into the frame buffer
   and the transmit shipper */
`timescale 1ns/10ps

module rmii_port import rmii_pkg::*;
(
    input   wire                    clock,
    input   wire                    arst_n,
    input   wire    [DIBIT_W-1:0]   rmii_receive_data,
    input   wire                    rmii_receive_data_enable,
    input   wire                    rmii_receive_data_error,
    input   wire    [WORD_W-1:0]    transmit_data,
    input   wire                    transmit_data_enable,
    input   wire                    receive_data_enable,

    output  wire    [WORD_W-1:0]    receive_data,
    output  wire                    receive_data_valid,
    output  wire    [DIBIT_W-1:0]   rmii_transmit_data,
    output  wire                    rmii_transmit_data_valid
);

rx_byte_if  rx_bytes();
payload_if  payload();

////////////////////////////////////////
// Receive chain
////////////////////////////////////////
rmii_frame_decoder rmii_frame_decoder(
    .clock                      (clock),
    .arst_n                     (arst_n),
    .rmii_receive_data          (rmii_receive_data),
    .rmii_receive_data_enable   (rmii_receive_data_enable),
    .rmii_receive_data_error    (rmii_receive_data_error),
    .rx_bytes                   (rx_bytes)
);

fcs_checker fcs_checker(
    .clock                      (clock),
    .arst_n                     (arst_n),
    .rx_bytes                   (rx_bytes),
    .payload                    (payload)
);

frame_buffer frame_buffer(
    .clock                      (clock),
    .arst_n                     (arst_n),
    .payload                    (payload),
    .receive_data_enable        (receive_data_enable),
    .receive_data               (receive_data),
    .receive_data_valid         (receive_data_valid)
);

////////////////////////////////////////
// Transmit side
////////////////////////////////////////
rmii_transmit_shipper rmii_transmit_shipper(
    .clock                      (clock),
    .arst_n                     (arst_n),
    .transmit_data              (transmit_data),
    .transmit_data_enable       (transmit_data_enable),
    .rmii_transmit_data         (rmii_transmit_data),
    .rmii_transmit_data_valid   (rmii_transmit_data_valid)
);

endmodule

// File: tb/tb_frame_tasks.svh
/* Testbench tasks for frame building with its own CRC-32, RMII frame
   sending and user word reads */
`ifndef TB_FRAME_TASKS_SVH
`define TB_FRAME_TASKS_SVH

// Reflected CRC-32 of frame_bytes inverted for the FCS
function automatic logic [CRC_W-1:0] frame_crc();
    logic [CRC_W-1:0]   r;
    logic               feedback;
    r = CRC_INIT;
    foreach (frame_bytes[n]) begin
        for (int b = 0; b < BYTE_W; b++) begin
            feedback = r[0] ^ frame_bytes[n][b];
            r = {1'b0, r[CRC_W-1:1]};
            if (feedback) begin
                r = r ^ CRC_POLY;
            end
        end
    end
    return ~r;
endfunction

// Random payload and FCS that reach the scoreboard only when keep is set
task automatic build_frame(input int payload_len, input bit keep);
    logic [CRC_W-1:0] fcs;
    frame_bytes.delete();
    for (int n = 0; n < payload_len; n++) begin
        frame_bytes.push_back(8'($random(seed)));
    end
    fcs = frame_crc();
    if (keep) begin
        foreach (frame_bytes[n]) begin
            expected_words.push_back({n == payload_len - 1, frame_bytes[n]});
        end
    end
    for (int k = 0; k < FCS_BYTES; k++) begin
        frame_bytes.push_back(fcs[8*k +: 8]);
    end
endtask

task automatic send_dibit(input logic [DIBIT_W-1:0] value, input logic error);
    @(posedge clock);
    rmii_receive_data           <= value;
    rmii_receive_data_enable    <= 1'b1;
    rmii_receive_data_error     <= error;
endtask

// Preamble, delimiter, bytes LSB dibit first, then the gap
task automatic send_frame(input int error_dibit);
    int index;
    index = 0;
    for (int p = 0; p < 31; p++) begin
        send_dibit(PREAMBLE_DIBIT, 1'b0);
    end
    send_dibit(SFD_DIBIT, 1'b0);
    foreach (frame_bytes[n]) begin
        for (int d = 0; d < DIBITS_PER_BYTE; d++) begin
            send_dibit(frame_bytes[n][2*d +: 2], index == error_dibit);
            index++;
        end
    end
    @(posedge clock);
    rmii_receive_data           <= '0;
    rmii_receive_data_enable    <= 1'b0;
    rmii_receive_data_error     <= 1'b0;
    repeat (12) @(posedge clock);
endtask

// One cycle pop strobe, then sample at the falling edge
task automatic pulse_pop();
    @(posedge clock);
    receive_data_enable <= 1'b1;
    @(posedge clock);
    receive_data_enable <= 1'b0;
    @(negedge clock);
endtask

`endif

// File: tb/tb_rmii_port.sv
/* Testbench of the RMII port with good, corrupt, errored and runt frames,
   transmit dibit order and frame gaps */
`timescale 1ns/10ps

module tb_rmii_port import rmii_pkg::*;
();

logic                   clock;
logic                   arst_n;
logic   [DIBIT_W-1:0]   rmii_receive_data;
logic                   rmii_receive_data_enable;
logic                   rmii_receive_data_error;
logic   [WORD_W-1:0]    transmit_data;
logic                   transmit_data_enable;
logic                   receive_data_enable;
logic   [WORD_W-1:0]    receive_data;
logic                   receive_data_valid;
logic   [DIBIT_W-1:0]   rmii_transmit_data;
logic                   rmii_transmit_data_valid;

integer                 seed = 55;
logic   [BYTE_W-1:0]    frame_bytes     [$];
logic   [WORD_W-1:0]    expected_words  [$];
logic   [WORD_W-1:0]    tx_expected     [$];
logic   [WORD_W-1:0]    tx_word;
logic   [BYTE_W-1:0]    tx_byte;
int                     tx_dibit_count  = 0;
bit                     gap_required    = 1'b0;
logic                   pop_seen        = 1'b0;
int                     value_errors    = 0;
int                     timeout_errors  = 0;

task automatic report_error(input string msg);
    $display("FAILED at time %0t: %s", $time, msg);
    value_errors++;
endtask

`include "tb_frame_tasks.svh"

// Pops up to the word flagged last and checks each against the scoreboard
task automatic read_frame();
    logic [WORD_W-1:0]  expect_word;
    int                 tries;
    bit                 started;
    bit                 done;
    tries = 0;
    started = 1'b0;
    done = 1'b0;
    while (!done) begin
        pulse_pop();
        if (receive_data_valid) begin
            assert (expected_words.size() != 0)
                else report_error("word read while no word was expected");
            if (expected_words.size() == 0) begin
                done = 1'b1;
            end else begin
                started = 1'b1;
                expect_word = expected_words.pop_front();
                assert (receive_data == expect_word) else report_error(
                    $sformatf("read %h, expected %h", receive_data, expect_word));
                done = expect_word[WORD_W-1];
            end
        end else begin
            assert (!started)
                else report_error("receive_data_valid missing one cycle after a pop");
            if (started) begin
                done = 1'b1;
            end else begin
                tries++;
                if (tries == 100) begin
                    $display("Timeout: no frame became readable in the buffer");
                    timeout_errors++;
                    done = 1'b1;
                end
            end
        end
    end
endtask

task automatic expect_no_words();
    repeat (8) begin
        pulse_pop();
        assert (!receive_data_valid) else report_error("word read from a dropped frame");
    end
endtask

initial begin
    clock = 1'b0;
    forever begin
        #20 clock = ~clock;
    end
end

rmii_port dut(
    .clock                      (clock),
    .arst_n                     (arst_n),
    .rmii_receive_data          (rmii_receive_data),
    .rmii_receive_data_enable   (rmii_receive_data_enable),
    .rmii_receive_data_error    (rmii_receive_data_error),
    .transmit_data              (transmit_data),
    .transmit_data_enable       (transmit_data_enable),
    .receive_data_enable        (receive_data_enable),
    .receive_data               (receive_data),
    .receive_data_valid         (receive_data_valid),
    .rmii_transmit_data         (rmii_transmit_data),
    .rmii_transmit_data_valid   (rmii_transmit_data_valid)
);

////////////////////////////////////////
// Monitors
////////////////////////////////////////
always @(posedge clock) begin
    pop_seen <= receive_data_enable;
end

always @(negedge clock) begin
    if (receive_data_valid) begin
        assert (pop_seen) else report_error("receive_data_valid without a pop");
    end
end

// Regroup transmit dibits into bytes
always @(negedge clock) begin
    if (gap_required) begin
        assert (!rmii_transmit_data_valid) else report_error("no idle cycle after last word");
        gap_required = 1'b0;
    end
    if (rmii_transmit_data_valid) begin
        tx_byte = {rmii_transmit_data, tx_byte[BYTE_W-1:DIBIT_W]};
        tx_dibit_count++;
        if (tx_dibit_count == DIBITS_PER_BYTE) begin
            tx_dibit_count = 0;
            assert (tx_expected.size() != 0)
                else report_error("transmit byte with nothing queued");
            if (tx_expected.size() != 0) begin
                tx_word = tx_expected.pop_front();
                assert (tx_byte == tx_word[BYTE_W-1:0]) else report_error(
                    $sformatf("shipped %h, expected %h", tx_byte, tx_word[BYTE_W-1:0]));
                gap_required = tx_word[WORD_W-1];
            end
        end
    end
end

////////////////////////////////////////
// Stimulus
////////////////////////////////////////
initial begin
    logic [WORD_W-1:0]  word;
    int                 waited;
    arst_n = 1'b0;
    rmii_receive_data = '0;
    rmii_receive_data_enable = 1'b0;
    rmii_receive_data_error = 1'b0;
    transmit_data = '0;
    transmit_data_enable = 1'b0;
    receive_data_enable = 1'b0;
    repeat (8) @(posedge clock);
    arst_n <= 1'b1;

    repeat (10) begin
        @(negedge clock);
        assert (!receive_data_valid && !rmii_transmit_data_valid)
            else report_error("valid high before any stimulus");
    end

    build_frame(64 + ($unsigned($random(seed)) % 40), 1'b1);
    send_frame(-1);
    read_frame();

    // CRC failure, then a clean frame
    build_frame(70, 1'b0);
    frame_bytes[10] = frame_bytes[10] ^ 8'h04;
    send_frame(-1);
    expect_no_words();
    build_frame(64 + ($unsigned($random(seed)) % 40), 1'b1);
    send_frame(-1);
    read_frame();

    // Receive error on one dibit, then a runt
    build_frame(80, 1'b0);
    send_frame(37);
    build_frame(20, 1'b0);
    send_frame(-1);
    expect_no_words();
    build_frame(60, 1'b1);
    send_frame(-1);
    read_frame();
    expect_no_words();

    // Two transmit frames of five and four bytes
    for (int n = 0; n < 9; n++) begin
        word = {n == 4 || n == 8, 8'($random(seed))};
        tx_expected.push_back(word);
        @(posedge clock);
        transmit_data <= word;
        transmit_data_enable <= 1'b1;
    end
    @(posedge clock);
    transmit_data_enable <= 1'b0;
    waited = 0;
    while ((tx_expected.size() != 0 || gap_required) && waited < 400) begin
        @(negedge clock);
        waited++;
    end
    if (tx_expected.size() != 0) begin
        $display("Timeout: %0d transmit bytes never shipped", tx_expected.size());
        timeout_errors++;
    end

    $display("Errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
        $display("STATUS: PASS");
    end else begin
        $display("STATUS: FAIL");
    end
    $finish;
end

endmodule

// File: all.f
+incdir+tb
source/rmii_pkg.sv
source/rx_byte_if.sv
source/payload_if.sv
source/rmii_frame_decoder.sv
source/fcs_checker.sv
source/frame_buffer.sv
source/rmii_transmit_shipper.sv
source/rmii_port.sv
tb/tb_rmii_port.sv
